// File: filelist.f
+incdir+.
pkg_tpu_data.sv
pkg_tpu_ctrl.sv
issue_ctrl.sv
lane_regfile.sv
path_sel.sv
lane_alu.sv
lane.sv
simd_unit.sv
tb_simd_unit.sv

// File: issue_ctrl.sv
//////////////////////////////////////////////////
// Instruction latch and issue sequencer
// Drives read, execute and write-back strobes
//////////////////////////////////////////////////

`timescale 1ns/100ps

module issue_ctrl
	import pkg_tpu_data::*;
	import pkg_tpu_ctrl::*;
(
	input	logic			clock,
	input	logic			arst_n,
	input	logic			instr_valid,		// One-cycle strobe
	input	opcode_t		opcode,
	input	reg_addr_t		dst,
	input	reg_addr_t		src1,
	input	reg_addr_t		src2,
	input	reg_addr_t		src3,
	input	path_sel_t		sel_path,			// Operand route
	input	path_sel_t		sel_path_wb,		// Write-back route
	input	data_t			scalar,
	output	logic			busy,
	output	logic			rd_en,
	output	logic			ex_en,
	output	logic			wr_en,
	output	opcode_t		op,
	output	path_sel_t		wb_sel,
	output	path_sel_t		op_sel,
	output	reg_addr_t		dst_q,
	output	reg_addr_t		src1_q,
	output	reg_addr_t		src2_q,
	output	reg_addr_t		src3_q,
	output	data_t			scalar_q
);

	seq_state_t		state;
	seq_state_t		state_nxt;
	logic			accept;

	assign accept = (state == ST_IDLE) && instr_valid;	// Dropped while busy

	//////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////

	always_comb begin
		case (state)
			ST_IDLE:	state_nxt = accept ? ST_READ : ST_IDLE;
			ST_READ:	state_nxt = ST_EXEC;
			ST_EXEC:	state_nxt = ST_WB;
			default:	state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	assign busy		= (state != ST_IDLE);
	assign rd_en	= (state == ST_READ);
	assign ex_en	= (state == ST_EXEC);
	assign wr_en	= (state == ST_WB);

	//////////////////////////////////////////////////
	// Instruction latch
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			op			<= OP_ADD;
			op_sel		<= '0;
			wb_sel		<= '0;
			dst_q		<= '0;
			src1_q		<= '0;
			src2_q		<= '0;
			src3_q		<= '0;
			scalar_q	<= '0;
		end else if (accept) begin
			op			<= opcode;
			op_sel		<= sel_path;
			wb_sel		<= sel_path_wb;
			dst_q		<= dst;
			src1_q		<= src1;
			src2_q		<= src2;
			src3_q		<= src3;
			scalar_q	<= scalar;
		end
	end

	// Strobes never overlap
	a_strobe_onehot: assert property (@(posedge clock) disable iff (!arst_n)
		$onehot0({rd_en, ex_en, wr_en}));

	// Write back always lands one cycle after the ALU step
	a_wr_after_ex: assert property (@(posedge clock) disable iff (!arst_n)
		ex_en |=> wr_en);
	a_wr_needs_ex: assert property (@(posedge clock) disable iff (!arst_n)
		wr_en |-> $past(ex_en));

endmodule

// File: lane.sv
//////////////////////////////////////////////////
// One SIMD lane
// Register file, routing and ALU
//////////////////////////////////////////////////

`timescale 1ns/100ps

module lane
	import pkg_tpu_data::*;
	import pkg_tpu_ctrl::*;
#(
	parameter int LANE_ID = 0
)(
	input	logic			clock,
	input	logic			arst_n,
	input	logic			rd_en,
	input	logic			ex_en,
	input	logic			wr_en,
	input	opcode_t		op,
	input	path_sel_t		sel_path,
	input	path_sel_t		sel_path_wb,
	input	reg_addr_t		dst,
	input	reg_addr_t		src1,
	input	reg_addr_t		src2,
	input	reg_addr_t		src3,
	input	data_t			scalar,
	input	lane_t			lane_src1,			// Gathered from all lanes
	input	lane_t			lane_src2,
	input	lane_t			lane_src3,
	input	lane_t			lane_res,
	output	data_t			src_out1,			// Own slot of the lane arrays
	output	data_t			src_out2,
	output	data_t			src_out3,
	output	data_t			res_out,
	output	data_t			wb_data
);

	logic	req;
	data_t	src_data1;
	data_t	src_data2;
	data_t	src_data3;
	data_t	opnd1;
	data_t	opnd2;
	data_t	opnd3;

	// High through the execute cycle, when read data is valid
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			req <= 1'b0;
		end else begin
			req <= rd_en;
		end
	end

	lane_regfile u_regfile (
		.clock, .arst_n, .rd_en,
		.rd_addr1 (src1), .rd_addr2 (src2), .rd_addr3 (src3),
		.wr_en, .wr_addr (dst), .wr_data (wb_data),
		.rd_data1 (src_data1), .rd_data2 (src_data2), .rd_data3 (src_data3)
	);

	path_sel #(.LANE_ID(LANE_ID)) u_path_sel (
		.req, .sel_path, .sel_path_wb, .scalar,
		.lane_src1, .lane_src2, .lane_src3, .lane_res,
		.src_data1, .src_data2, .src_data3, .alu_res (res_out),
		.opnd1, .opnd2, .opnd3, .wb_data,
		.lane_out1 (src_out1), .lane_out2 (src_out2), .lane_out3 (src_out3)
	);

	lane_alu #(.LANE_ID(LANE_ID)) u_alu (
		.clock, .arst_n, .ex_en, .op,
		.opnd1, .opnd2, .opnd3, .result (res_out)
	);

	// Route output must be resolved when it reaches the register file
	a_wb_known: assert property (@(posedge clock) disable iff (!arst_n)
		wr_en |-> !$isunknown(wb_data));

endmodule

// File: lane_alu.sv
//////////////////////////////////////////////////
// Per-lane ALU with registered result
//////////////////////////////////////////////////

`timescale 1ns/100ps

module lane_alu
	import pkg_tpu_data::*;
	import pkg_tpu_ctrl::*;
#(
	parameter int LANE_ID = 0
)(
	input	logic			clock,
	input	logic			arst_n,
	input	logic			ex_en,				// Captures the result
	input	opcode_t		op,
	input	data_t			opnd1,
	input	data_t			opnd2,
	input	data_t			opnd3,
	output	data_t			result
);

	data_t	alu_val;
	data_t	product;

	assign product = opnd1 * opnd2;			// Low word only

	always_comb begin
		case (op)
			OP_ADD:		alu_val = opnd1 + opnd2;
			OP_SUB:		alu_val = opnd1 - opnd2;
			OP_MUL:		alu_val = product;
			OP_AND:		alu_val = opnd1 & opnd2;
			OP_XOR:		alu_val = opnd1 ^ opnd2;
			OP_MAD:		alu_val = product + opnd3;
			OP_LID:		alu_val = opnd1 + data_t'(LANE_ID);
			default:	alu_val = '0;		// Unused encoding
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			result <= '0;
		end else if (ex_en) begin
			result <= alu_val;
		end
	end

endmodule

// File: lane_regfile.sv
//////////////////////////////////////////////////
// Per-lane register file
// Three registered read ports, one write port
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "tpu_defines.svh"

module lane_regfile
	import pkg_tpu_data::*;
#(
	parameter int NUM_REGS = `TPU_NUM_REGS
)(
	input	logic			clock,
	input	logic			arst_n,
	input	logic			rd_en,				// Samples all three read ports
	input	reg_addr_t		rd_addr1,
	input	reg_addr_t		rd_addr2,
	input	reg_addr_t		rd_addr3,
	input	logic			wr_en,
	input	reg_addr_t		wr_addr,
	input	data_t			wr_data,
	output	data_t			rd_data1,
	output	data_t			rd_data2,
	output	data_t			rd_data3
);

	data_t	regs [NUM_REGS];

	// Storage, cleared so every lane starts from zero
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Read data held until the next rd_en
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			rd_data1 <= '0;
			rd_data2 <= '0;
			rd_data3 <= '0;
		end else if (rd_en) begin
			rd_data1 <= regs[rd_addr1];
			rd_data2 <= regs[rd_addr2];
			rd_data3 <= regs[rd_addr3];
		end
	end

endmodule

// File: path_sel.sv
//////////////////////////////////////////////////
// Operand and write-back routing for one lane
// Local, scalar or rotated cross-lane sources
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "tpu_defines.svh"

module path_sel
	import pkg_tpu_data::*;
	import pkg_tpu_ctrl::*;
#(
	parameter int LANE_ID = 0
)(
	input	logic			req,				// Export local sources
	input	path_sel_t		sel_path,
	input	path_sel_t		sel_path_wb,
	input	data_t			scalar,
	input	lane_t			lane_src1,			// Operand 1 of every lane
	input	lane_t			lane_src2,
	input	lane_t			lane_src3,
	input	lane_t			lane_res,			// ALU result of every lane
	input	data_t			src_data1,			// From own register file
	input	data_t			src_data2,
	input	data_t			src_data3,
	input	data_t			alu_res,			// From own ALU
	output	data_t			opnd1,
	output	data_t			opnd2,
	output	data_t			opnd3,
	output	data_t			wb_data,
	output	data_t			lane_out1,
	output	data_t			lane_out2,
	output	data_t			lane_out3
);

	logic	[3:0]	op_sum;
	logic	[3:0]	wb_sum;
	lane_idx_t		op_lane;
	lane_idx_t		wb_lane;
	data_t			op_local;
	data_t			wb_local;

	// Offset rotated by own index, wraps around the cluster
	assign op_sum	= sel_path[3:0] + 4'(LANE_ID);
	assign wb_sum	= sel_path_wb[3:0] + 4'(LANE_ID);
	assign op_lane	= lane_idx_t'(op_sum % `TPU_NUM_LANES);
	assign wb_lane	= lane_idx_t'(wb_sum % `TPU_NUM_LANES);

	// One local pick shared by all three operands
	always_comb begin
		case (sel_path[1:0])
			2'd1:		op_local = src_data1;
			2'd2:		op_local = src_data2;
			2'd3:		op_local = src_data3;
			default:	op_local = scalar;
		endcase
	end

	always_comb begin
		case (sel_path_wb[1:0])
			2'd1:		wb_local = src_data1;
			2'd2:		wb_local = src_data2;
			2'd3:		wb_local = src_data3;
			default:	wb_local = alu_res;
		endcase
	end

	assign opnd1	= sel_path[4] ? lane_src1[op_lane] : op_local;
	assign opnd2	= sel_path[4] ? lane_src2[op_lane] : op_local;
	assign opnd3	= sel_path[4] ? lane_src3[op_lane] : op_local;
	assign wb_data	= sel_path_wb[4] ? lane_res[wb_lane] : wb_local;

	assign lane_out1	= req ? src_data1 : '0;	// Zero outside the request window
	assign lane_out2	= req ? src_data2 : '0;
	assign lane_out3	= req ? src_data3 : '0;

endmodule

// File: pkg_tpu_ctrl.sv
//////////////////////////////////////////////////
// Control types
// Route code, opcode and sequencer state enums
//////////////////////////////////////////////////

`include "tpu_defines.svh"

package pkg_tpu_ctrl;

	// Route code
	// Bit 4 set takes a lane picked by bits 3..0 plus own index
	// Bit 4 clear uses bits 1..0 as a local pick
	typedef logic [`TPU_PATH_W-1:0] path_sel_t;

	// ALU functions
	typedef enum logic [`TPU_OP_W-1:0] {
		OP_ADD	= 3'd0,		// op1 + op2
		OP_SUB	= 3'd1,		// op1 - op2
		OP_MUL	= 3'd2,		// Low word of op1 * op2
		OP_AND	= 3'd3,		// Bitwise
		OP_XOR	= 3'd4,		// Bitwise
		OP_MAD	= 3'd5,		// op1 * op2 + op3
		OP_LID	= 3'd6		// op1 + lane index
	} opcode_t;

	// Issue sequencer
	typedef enum logic [1:0] {
		ST_IDLE	= 2'd0,		// Waiting for an instruction
		ST_READ	= 2'd1,		// Register file read
		ST_EXEC	= 2'd2,		// ALU step
		ST_WB	= 2'd3		// Write back
	} seq_state_t;

endpackage

// File: pkg_tpu_data.sv
//////////////////////////////////////////////////
// Datapath types
// Operand, register index, lane index, lane array
//////////////////////////////////////////////////

`include "tpu_defines.svh"

package pkg_tpu_data;

	// One operand or result word
	typedef logic [`TPU_DATA_W-1:0]		data_t;

	// Register index inside one lane
	typedef logic [`TPU_REG_AW-1:0]		reg_addr_t;

	// Lane number, used for cross-lane picks
	typedef logic [`TPU_LANE_AW-1:0]	lane_idx_t;

	// One word per lane, slot n belongs to lane n
	typedef data_t [`TPU_NUM_LANES-1:0]	lane_t;

endpackage

// File: simd_unit.sv
//////////////////////////////////////////////////
// Four-lane SIMD cluster top level
// Sequencer, lanes and lane array gathering
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "tpu_defines.svh"

module simd_unit
	import pkg_tpu_data::*;
	import pkg_tpu_ctrl::*;
(
	input	logic			clock,
	input	logic			arst_n,
	input	logic			instr_valid,
	input	opcode_t		opcode,
	input	reg_addr_t		dst,
	input	reg_addr_t		src1,
	input	reg_addr_t		src2,
	input	reg_addr_t		src3,
	input	path_sel_t		sel_path,
	input	path_sel_t		sel_path_wb,
	input	data_t			scalar,
	output	logic			busy,
	output	logic			wb_valid,			// Pulses with the write
	output	reg_addr_t		wb_addr,
	output	lane_t			wb_data
);

	logic		rd_en;
	logic		ex_en;
	logic		wr_en;
	opcode_t	op;
	path_sel_t	wb_sel;
	path_sel_t	op_sel;
	reg_addr_t	dst_q;
	reg_addr_t	src1_q;
	reg_addr_t	src2_q;
	reg_addr_t	src3_q;
	data_t		scalar_q;
	lane_t		lane_src1;
	lane_t		lane_src2;
	lane_t		lane_src3;
	lane_t		lane_res;

	issue_ctrl u_issue (
		.clock, .arst_n, .instr_valid, .opcode,
		.dst, .src1, .src2, .src3, .sel_path, .sel_path_wb, .scalar,
		.busy, .rd_en, .ex_en, .wr_en, .op, .wb_sel, .op_sel,
		.dst_q, .src1_q, .src2_q, .src3_q, .scalar_q
	);

	assign wb_valid	= wr_en;
	assign wb_addr	= dst_q;

	// Each lane fills its own slot of the shared arrays
	for (genvar i = 0; i < `TPU_NUM_LANES; i++) begin : g_lane
		lane #(.LANE_ID(i)) u_lane (
			.clock, .arst_n, .rd_en, .ex_en, .wr_en, .op,
			.sel_path (op_sel), .sel_path_wb (wb_sel),
			.dst (dst_q), .src1 (src1_q), .src2 (src2_q), .src3 (src3_q),
			.scalar (scalar_q),
			.lane_src1, .lane_src2, .lane_src3, .lane_res,
			.src_out1 (lane_src1[i]), .src_out2 (lane_src2[i]), .src_out3 (lane_src3[i]),
			.res_out (lane_res[i]), .wb_data (wb_data[i])
		);
	end

endmodule

// File: tb_simd_unit.sv
//////////////////////////////////////////////////
// Testbench for the four-lane SIMD cluster
// Lane register model, random stimulus, checking assertions
// Watchdog bounded by the instruction count
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "tpu_defines.svh"

module tb_simd_unit
	import pkg_tpu_data::*;
	import pkg_tpu_ctrl::*;
();

	localparam int NL = `TPU_NUM_LANES;
	localparam int N_TESTS = 4 + 24 + 8 + 8 + 4 + `TPU_NUM_REGS;	// Accepted instructions
	localparam int WATCHDOG_CYCLES = N_TESTS * 6 + 50;

	logic		clock, arst_n, instr_valid, busy, wb_valid;
	opcode_t	opcode;
	reg_addr_t	dst, src1, src2, src3, wb_addr;
	path_sel_t	sel_path, sel_path_wb;
	data_t		scalar;
	lane_t		wb_data;

	data_t		model_regs [NL][`TPU_NUM_REGS];		// Expected register contents
	lane_t		exp_data;							// Expected write-back per lane
	reg_addr_t	exp_addr;
	string		exp_name;							// Test owning the instruction in flight
	int			err_cnt;

	simd_unit i_dut (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	initial begin
		#(WATCHDOG_CYCLES * 100);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

	task automatic note_failure(input string what);
		$display("%s", what);
		err_cnt++;
	endtask

	task automatic report_mismatch(input string field, input logic [127:0] expected,
		input logic [127:0] actual);
		$display("mismatch %s %s expected %0h actual %0h", exp_name, field, expected, actual);
		err_cnt++;
	endtask

	// Reference ALU from the opcode definitions
	function automatic data_t alu_ref(opcode_t f, data_t a, data_t b, data_t c, int lane_id);
		case (f)
			OP_ADD:		return a + b;
			OP_SUB:		return a - b;
			OP_MUL:		return a * b;			// Low word
			OP_AND:		return a & b;
			OP_XOR:		return a ^ b;
			OP_MAD:		return a * b + c;
			OP_LID:		return a + data_t'(lane_id);
			default:	return '0;
		endcase
	endfunction

	// Waits for an idle cluster, updates the model and strobes one instruction
	task automatic issue_instr(input string name, input opcode_t f, input reg_addr_t d,
		input reg_addr_t s1, input reg_addr_t s2, input reg_addr_t s3,
		input path_sel_t sp, input path_sel_t spwb, input data_t sc);
		data_t	rd [NL][3];
		data_t	opnd [3];
		data_t	res [NL];
		@(posedge clock);
		while (busy) begin
			@(posedge clock);
		end
		for (int l = 0; l < NL; l++) begin
			rd[l] = '{model_regs[l][s1], model_regs[l][s2], model_regs[l][s3]};
		end
		for (int l = 0; l < NL; l++) begin
			for (int k = 0; k < 3; k++) begin
				if (sp[4])
					opnd[k] = rd[(int'(sp[3:0]) + l) % NL][k];		// Rotated lane
				else
					opnd[k] = (sp[1:0] == 2'd0) ? sc : rd[l][int'(sp[1:0]) - 1];
			end
			res[l] = alu_ref(f, opnd[0], opnd[1], opnd[2], l);
		end
		for (int l = 0; l < NL; l++) begin
			if (spwb[4])
				exp_data[l] = res[(int'(spwb[3:0]) + l) % NL];
			else
				exp_data[l] = (spwb[1:0] == 2'd0) ? res[l] : rd[l][int'(spwb[1:0]) - 1];
			model_regs[l][d] = exp_data[l];
		end
		exp_addr = d;
		exp_name = name;
		instr_valid <= 1'b1;
		opcode <= f;
		{dst, src1, src2, src3} <= {d, s1, s2, s3};
		{sel_path, sel_path_wb, scalar} <= {sp, spwb, sc};
		@(posedge clock);
		instr_valid <= 1'b0;
	endtask

	// Strobe into a busy cluster, nothing in the model changes
	task automatic strobe_while_busy();
		@(posedge clock);
		instr_valid <= 1'b1;
		dst <= reg_addr_t'($urandom());
		scalar <= $urandom();
		@(posedge clock);
		instr_valid <= 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	a_wb_data: assert property (@(posedge clock) disable iff (!arst_n)
		wb_valid |-> wb_data == exp_data)
		else report_mismatch("wb_data", $sampled(exp_data), $sampled(wb_data));
	a_wb_addr: assert property (@(posedge clock) disable iff (!arst_n)
		wb_valid |-> wb_addr == exp_addr)
		else report_mismatch("wb_addr", $sampled(exp_addr), $sampled(wb_addr));
	a_wb_latency: assert property (@(posedge clock) disable iff (!arst_n)
		(instr_valid && !busy) |-> ##3 wb_valid)
		else note_failure("wb_valid missing three cycles after acceptance");
	a_busy_len: assert property (@(posedge clock) disable iff (!arst_n)
		(instr_valid && !busy) |=> busy [*3] ##1 !busy)
		else note_failure("busy not high for exactly three cycles");
	a_wb_cause: assert property (@(posedge clock) disable iff (!arst_n)
		wb_valid |-> $past(instr_valid && !busy, 3))
		else note_failure("wb_valid pulse without an accepted instruction");
	a_busy_cause: assert property (@(posedge clock) disable iff (!arst_n)
		(!busy && !instr_valid) |=> !busy)
		else note_failure("busy rose without an instruction strobe");

	initial begin
		void'($urandom(32'hae0e));
		arst_n = 1'b0;
		opcode = OP_ADD;
		{instr_valid, dst, src1, src2, src3, sel_path, sel_path_wb, scalar} = '0;
		model_regs = '{default: '0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clock);
			assert (busy === 1'b0 && wb_valid === 1'b0)
				else note_failure("busy or wb_valid high around reset");
			if (i == 7)
				arst_n <= 1'b1;							// Eight cycles in reset
		end
		for (int i = 0; i < 4; i++) begin
			issue_instr("lane_id", OP_LID, reg_addr_t'(i + 1), '0, '0, '0, 5'd0, 5'd0,
				$urandom());
		end
		// Registers 1 to 4 keep their per-lane values for the cross-lane tests
		for (int i = 0; i < 24; i++) begin
			issue_instr("local_alu", opcode_t'($urandom_range(5)),
				reg_addr_t'($urandom_range(15, 5)),
				reg_addr_t'($urandom()), reg_addr_t'($urandom()), reg_addr_t'($urandom()),
				path_sel_t'($urandom_range(3)), 5'd0, $urandom());
		end
		// Offsets past the lane count wrap around
		for (int i = 0; i < 8; i++) begin
			issue_instr("cross_lane", OP_MAD, reg_addr_t'(8 + i), reg_addr_t'(i % 4 + 1),
				reg_addr_t'((i + 1) % 4 + 1), reg_addr_t'((i + 2) % 4 + 1),
				path_sel_t'(16 + i), 5'd0, '0);
		end
		for (int i = 0; i < 8; i++) begin
			issue_instr("wb_route", opcode_t'($urandom_range(5)), reg_addr_t'($urandom()),
				reg_addr_t'(i % 4 + 1), reg_addr_t'($urandom()), reg_addr_t'($urandom()),
				path_sel_t'(16 + $urandom_range(3)), path_sel_t'((i / 4) * 16 + i % 4),
				$urandom());
		end
		for (int i = 0; i < 4; i++) begin
			issue_instr("drop", OP_ADD, reg_addr_t'(i + 5), reg_addr_t'(i + 1),
				reg_addr_t'(i + 2), '0, 5'd1, 5'd0, '0);
			strobe_while_busy();
		end
		// Every register read back through the source route
		for (int r = 0; r < `TPU_NUM_REGS; r++) begin
			issue_instr("readback", OP_ADD, reg_addr_t'(r), reg_addr_t'(r), '0, '0, 5'd1, 5'd1,
				'0);
		end
		@(posedge clock);
		while (busy) begin
			@(posedge clock);
		end
		repeat (2) @(posedge clock);
		$display("tests %0d, errors %0d", N_TESTS, err_cnt);
		if (err_cnt == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: tpu_defines.svh
//////////////////////////////////////////////////
// Cluster geometry and field widths
// Lane count, operand width, register file size
//////////////////////////////////////////////////

`ifndef TPU_DEFINES_SVH
`define TPU_DEFINES_SVH

// Lane geometry
`define TPU_NUM_LANES	4		// Lanes in the cluster
`define TPU_LANE_AW		2		// Bits to index a lane

// Datapath
`define TPU_DATA_W		32		// Operand width

// Register file
`define TPU_NUM_REGS	16		// Registers per lane
`define TPU_REG_AW		4		// Register address width

// Instruction fields
`define TPU_PATH_W		5		// Route code width
`define TPU_OP_W		3		// Opcode width

`endif
